/* src/board_ctrl_config.svh */
// board control constants: sync depths, bus widths, configuration port words and opcodes

`ifndef BOARD_CTRL_CONFIG_SVH
`define BOARD_CTRL_CONFIG_SVH

// core reset release stages after lock
`define RESET_SYNC_STAGES 4

// depth of the input synchronizers
`define SYNC_STAGES 2

// flash data lines
`define QSPI_DQ_W 4

// configuration port word width
`define ICAP_W 32

// words of the IPROG sequence
`define CFG_DUMMY_WORD 32'hFFFF_FFFF
`define CFG_SYNC_WORD 32'hAA99_5566
`define CFG_IPROG_CMD 32'h0000_000F

// command register address
`define CFG_REG_CMD 14'd4

// type-1 header opcodes
`define CFG_OP_NOOP 2'd0
`define CFG_OP_WRITE 2'd2

`endif

/* src/board_ctrl_pkg.sv */
// board control package: configuration word union, type-1 header struct, flash pin struct

`include "board_ctrl_config.svh"

package board_ctrl_pkg;

    // type-1 packet header as seen by the configuration logic
    typedef struct packed {
        logic [2:0]  hdr_type;
        logic [1:0]  opcode;
        logic [13:0] reg_addr;
        logic [1:0]  reserved;
        logic [10:0] word_count;
    } cfg_type1_hdr_t;

    // one configuration word, either plain data or a packet header
    typedef union packed {
        logic [`ICAP_W-1:0] raw;
        cfg_type1_hdr_t     hdr;
    } cfg_word_t;

    // core side flash controls, registered toward the pins
    typedef struct packed {
        logic                  sck;
        logic                  cs;
        logic [`QSPI_DQ_W-1:0] dq_o;
        logic [`QSPI_DQ_W-1:0] dq_oe;
    } qspi_out_t;

endpackage

/* src/reset_sync.sv */
// reset conditioner: holds the core reset until PLL lock, then releases it through a stage chain

`timescale 1ns/1ps

module reset_sync #(
    parameter int STAGES = 4
) (
    input  logic clk_125mhz_int,
    input  logic reset,
    input  logic pll_locked,
    output logic core_reset
);

    logic [STAGES-1:0] rst_chain;

    // ones while reset or unlocked, zeros walk in afterwards
    always_ff @(posedge clk_125mhz_int) begin
        if (reset || !pll_locked) begin
            rst_chain <= '1;
        end else begin
            rst_chain <= {rst_chain[STAGES-2:0], 1'b0};
        end
    end

    // last stage drives the core
    assign core_reset = rst_chain[STAGES-1];

    // any board reset reaches the core on the next edge
    a_reset_reaches_core: assert property (
        @(posedge clk_125mhz_int) reset |=> core_reset
    ) else $error("core_reset not asserted after reset");

endmodule

/* src/signal_sync.sv */
// multi-bit synchronizer chain for asynchronous inputs

`timescale 1ns/1ps

module signal_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  logic             clk_125mhz_int,
    input  logic [WIDTH-1:0] async_in,
    output logic [WIDTH-1:0] sync_out
);

    // stage 0 is the metastable catch register
    logic [STAGES-1:0][WIDTH-1:0] sync_reg;

    always_ff @(posedge clk_125mhz_int) begin
        sync_reg <= {sync_reg[STAGES-2:0], async_in};
    end

    assign sync_out = sync_reg[STAGES-1];

endmodule

/* src/iprog_sequencer.sv */
// reboot sequencer: four-phase boot handshake and IPROG word sequence with byte-wise bit swap

`timescale 1ns/1ps

`include "board_ctrl_config.svh"

module iprog_sequencer (
    input  logic               clk_125mhz_int,
    input  logic               reset,
    input  logic               boot_req_sync,
    input  logic               icap_avail,
    output logic               boot_ack,
    output logic               icap_csib,
    output logic               icap_rdwrb,
    output logic [`ICAP_W-1:0] icap_data
);

    // state names follow the word on the port in that state
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_DUMMY = 3'd1;
    localparam logic [2:0] ST_SYNC  = 3'd2;
    localparam logic [2:0] ST_NOOP0 = 3'd3;
    localparam logic [2:0] ST_WRITE = 3'd4;
    localparam logic [2:0] ST_IPROG = 3'd5;
    localparam logic [2:0] ST_NOOP1 = 3'd6;
    localparam logic [2:0] ST_ACK   = 3'd7;

    localparam logic [2:0] HDR_TYPE1 = 3'd1;

    logic [2:0] state;
    logic [2:0] state_next;
    logic       csib_reg;
    logic       ack_reg;
    logic [`ICAP_W-1:0] data_reg;

    board_ctrl_pkg::cfg_word_t word_next;

    // word presented to the port in a given state
    function automatic board_ctrl_pkg::cfg_word_t word_for(input logic [2:0] st);
        board_ctrl_pkg::cfg_word_t w;
        w.raw = `CFG_DUMMY_WORD;
        case (st)
            ST_SYNC: begin
                w.raw = `CFG_SYNC_WORD;
            end
            ST_NOOP0, ST_NOOP1: begin
                w.hdr.hdr_type   = HDR_TYPE1;
                w.hdr.opcode     = `CFG_OP_NOOP;
                w.hdr.reg_addr   = '0;
                w.hdr.reserved   = '0;
                w.hdr.word_count = '0;
            end
            ST_WRITE: begin
                // one word into the command register
                w.hdr.hdr_type   = HDR_TYPE1;
                w.hdr.opcode     = `CFG_OP_WRITE;
                w.hdr.reg_addr   = `CFG_REG_CMD;
                w.hdr.reserved   = '0;
                w.hdr.word_count = 11'd1;
            end
            ST_IPROG: begin
                w.raw = `CFG_IPROG_CMD;
            end
            default: begin
                w.raw = `CFG_DUMMY_WORD;
            end
        endcase
        return w;
    endfunction

    // port expects the bit order reversed inside each byte
    function automatic logic [`ICAP_W-1:0] bit_swap(input logic [`ICAP_W-1:0] din);
        logic [`ICAP_W-1:0] dout;
        dout = '0;
        for (int b = 0; b < `ICAP_W / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                dout[8*b + i] = din[8*b + 7 - i];
            end
        end
        return dout;
    endfunction

    always_comb begin
        state_next = ST_IDLE;
        case (state)
            ST_IDLE: begin
                if (boot_req_sync && !boot_ack && icap_avail) begin
                    state_next = ST_DUMMY;
                end
            end
            ST_DUMMY: state_next = ST_SYNC;
            ST_SYNC:  state_next = ST_NOOP0;
            ST_NOOP0: state_next = ST_WRITE;
            ST_WRITE: state_next = ST_IPROG;
            ST_IPROG: state_next = ST_NOOP1;
            ST_NOOP1: state_next = ST_ACK;
            ST_ACK: begin
                // hold ack until requester lets go
                state_next = boot_req_sync ? ST_ACK : ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
        if (reset) begin
            state_next = ST_IDLE;
        end
    end

    assign word_next = word_for(state_next);

    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            state     <= ST_IDLE;
            csib_reg  <= 1'b1;
            ack_reg   <= 1'b0;
        end else begin
            state     <= state_next;
            csib_reg  <= (state_next == ST_IDLE) || (state_next == ST_ACK);
            ack_reg   <= (state_next == ST_ACK);
        end
    end

    // data follows the next state, so idle shows the dummy word
    always_ff @(posedge clk_125mhz_int) begin
        data_reg <= bit_swap(word_next.raw);
    end

    assign icap_csib  = csib_reg;
    // the port is only ever written
    assign icap_rdwrb = 1'b0;
    assign boot_ack   = ack_reg;
    assign icap_data  = data_reg;

    a_write_only: assert property (
        @(posedge clk_125mhz_int) !icap_csib |-> !icap_rdwrb
    ) else $error("read cycle on configuration port");

    a_ack_after_burst: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) $rose(boot_ack) |-> icap_csib
    ) else $error("boot_ack rose during burst");

    a_burst_length: assert property (
        @(posedge clk_125mhz_int) disable iff (reset) $fell(icap_csib) |-> ##[1:6] icap_csib
    ) else $error("csib low longer than six cycles");

endmodule

/* src/qspi_pin_stage.sv */
// flash pin stage: output registers toward the pins and data input synchronizer

`timescale 1ns/1ps

`include "board_ctrl_config.svh"

module qspi_pin_stage (
    input  logic                      clk_125mhz_int,
    input  logic                      reset,
    input  board_ctrl_pkg::qspi_out_t qspi_core,
    input  logic [`QSPI_DQ_W-1:0]     qspi_dq_pin_in,
    output board_ctrl_pkg::qspi_out_t qspi_pins,
    output logic [`QSPI_DQ_W-1:0]     qspi_dq_core_in
);

    // chip deselected, clock low, data lines released
    localparam board_ctrl_pkg::qspi_out_t QSPI_IDLE = '{
        sck:   1'b0,
        cs:    1'b1,
        dq_o:  '0,
        dq_oe: '0
    };

    board_ctrl_pkg::qspi_out_t pins_reg;

    // one register stage so pin timing is set by the IOB flops
    always_ff @(posedge clk_125mhz_int) begin
        if (reset) begin
            pins_reg <= QSPI_IDLE;
        end else begin
            pins_reg <= qspi_core;
        end
    end

    assign qspi_pins = pins_reg;

    // returned data is asynchronous to the core clock
    signal_sync #(
        .WIDTH  (`QSPI_DQ_W),
        .STAGES (`SYNC_STAGES)
    ) dq_sync_inst (
        .clk_125mhz_int (clk_125mhz_int),
        .async_in       (qspi_dq_pin_in),
        .sync_out       (qspi_dq_core_in)
    );

endmodule

/* src/board_ctrl_top.sv */
// board control top level: reset conditioner, boot request sync, reboot sequencer, flash pin stage

`timescale 1ns/1ps

`include "board_ctrl_config.svh"

module board_ctrl_top (
    input  logic                      clk_125mhz_int,
    input  logic                      reset,
    input  logic                      pll_locked,
    input  logic                      boot_req,
    input  logic                      icap_avail,
    input  board_ctrl_pkg::qspi_out_t qspi_core,
    input  logic [`QSPI_DQ_W-1:0]     qspi_dq_pin_in,
    output logic                      core_reset,
    output logic                      boot_ack,
    output logic                      icap_csib,
    output logic                      icap_rdwrb,
    output logic [`ICAP_W-1:0]        icap_data,
    output board_ctrl_pkg::qspi_out_t qspi_pins,
    output logic [`QSPI_DQ_W-1:0]     qspi_dq_core_in
);

    logic boot_req_sync;

    // core reset for the application side
    reset_sync #(
        .STAGES (`RESET_SYNC_STAGES)
    ) reset_sync_inst (
        .clk_125mhz_int (clk_125mhz_int),
        .reset          (reset),
        .pll_locked     (pll_locked),
        .core_reset     (core_reset)
    );

    // boot request may come from another domain
    signal_sync #(
        .WIDTH  (1),
        .STAGES (`SYNC_STAGES)
    ) boot_sync_inst (
        .clk_125mhz_int (clk_125mhz_int),
        .async_in       (boot_req),
        .sync_out       (boot_req_sync)
    );

    iprog_sequencer iprog_inst (
        .clk_125mhz_int (clk_125mhz_int),
        .reset          (reset),
        .boot_req_sync  (boot_req_sync),
        .icap_avail     (icap_avail),
        .boot_ack       (boot_ack),
        .icap_csib      (icap_csib),
        .icap_rdwrb     (icap_rdwrb),
        .icap_data      (icap_data)
    );

    // flash pins
    qspi_pin_stage qspi_inst (
        .clk_125mhz_int  (clk_125mhz_int),
        .reset           (reset),
        .qspi_core       (qspi_core),
        .qspi_dq_pin_in  (qspi_dq_pin_in),
        .qspi_pins       (qspi_pins),
        .qspi_dq_core_in (qspi_dq_core_in)
    );

endmodule

/* test/tb_board_ctrl.sv */
// testbench for the board control top level: stimulus table, LFSR, check task and timeout

`timescale 1ns/1ps

module tb_board_ctrl;

    typedef enum logic [2:0] {
        OP_FLASH_OUT,
        OP_FLASH_IN,
        OP_BOOT,
        OP_BOOT_WAIT,
        OP_LOCK_DROP
    } op_kind_t;

    // count means vectors for flash, avail hold cycles for boot, lock-low cycles for lock drop
    typedef struct packed {
        op_kind_t   op;
        logic [7:0] count;
    } test_entry_t;

    localparam int TABLE_LEN = 11;

    localparam test_entry_t TEST_TABLE [TABLE_LEN] = '{
        '{OP_FLASH_OUT, 8'd100},
        '{OP_FLASH_IN,  8'd100},
        '{OP_BOOT,      8'd0},
        '{OP_BOOT_WAIT, 8'd9},
        '{OP_LOCK_DROP, 8'd6},
        '{OP_FLASH_OUT, 8'd80},
        '{OP_BOOT,      8'd0},
        '{OP_FLASH_IN,  8'd80},
        '{OP_BOOT_WAIT, 8'd4},
        '{OP_LOCK_DROP, 8'd3},
        '{OP_FLASH_OUT, 8'd50}
    };

    // reboot words in port order, before the bit swap
    localparam logic [31:0] IPROG_WORDS [6] = '{
        32'hFFFF_FFFF,
        32'hAA99_5566,
        32'h2000_0000,
        32'h3000_8001,
        32'h0000_000F,
        32'h2000_0000
    };

    localparam int SYNC_DEPTH = 2;
    localparam int RELEASE_EDGES = 4;

    // table runs in roughly 500 cycles
    localparam int RUN_CYCLES = 500;
    localparam int MAX_CYCLES = 4 * RUN_CYCLES;

    logic                      clk_125mhz_int;
    logic                      reset;
    logic                      pll_locked;
    logic                      boot_req;
    logic                      icap_avail;
    board_ctrl_pkg::qspi_out_t qspi_core;
    logic [3:0]                qspi_dq_pin_in;
    logic                      core_reset;
    logic                      boot_ack;
    logic                      icap_csib;
    logic                      icap_rdwrb;
    logic [31:0]               icap_data;
    board_ctrl_pkg::qspi_out_t qspi_pins;
    logic [3:0]                qspi_dq_core_in;

    logic [15:0] lfsr_state;
    int          error_count = 0;
    int          cycle_count = 0;

    board_ctrl_top DUT (
        .clk_125mhz_int  (clk_125mhz_int),
        .reset           (reset),
        .pll_locked      (pll_locked),
        .boot_req        (boot_req),
        .icap_avail      (icap_avail),
        .qspi_core       (qspi_core),
        .qspi_dq_pin_in  (qspi_dq_pin_in),
        .core_reset      (core_reset),
        .boot_ack        (boot_ack),
        .icap_csib       (icap_csib),
        .icap_rdwrb      (icap_rdwrb),
        .icap_data       (icap_data),
        .qspi_pins       (qspi_pins),
        .qspi_dq_core_in (qspi_dq_core_in)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    always @(posedge clk_125mhz_int) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the test table did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = {1'b0, s[15:1]};
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] swap_bits_in_bytes(input logic [31:0] w);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = {<<{w[8*b +: 8]}};
        end
        return r;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int nbits, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // outputs are sampled here, inputs are driven right after
    task automatic next_cycle();
        @(posedge clk_125mhz_int);
        #1;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // reset or lock was just released
    task automatic expect_core_release();
        for (int n = 1; n <= RELEASE_EDGES; n++) begin
            next_cycle();
            check_value(32'(core_reset), (n < RELEASE_EDGES) ? 32'd1 : 32'd0,
                        $sformatf("core_reset after release edge %0d", n));
        end
    endtask

    task automatic flash_out_burst(input int n);
        logic [15:0] rnd;
        logic [9:0]  sent;
        for (int i = 0; i < n; i++) begin
            take_bits(10, rnd);
            sent = rnd[9:0];
            qspi_core = sent;
            next_cycle();
            check_value({22'b0, qspi_pins}, {22'b0, sent}, "qspi_pins one cycle after core");
        end
    endtask

    task automatic flash_in_burst(input int n);
        logic [15:0] rnd;
        logic [3:0]  prev;
        prev = '0;
        for (int i = 0; i < n; i++) begin
            take_bits(4, rnd);
            qspi_dq_pin_in = rnd[3:0];
            next_cycle();
            if (i > 0) begin
                check_value(32'(qspi_dq_core_in), 32'(prev), "qspi_dq_core_in two cycles later");
            end
            prev = rnd[3:0];
        end
        next_cycle();
        check_value(32'(qspi_dq_core_in), 32'(prev), "qspi_dq_core_in last value");
    endtask

    // avail_hold cycles with icap_avail low before the start is allowed
    task automatic boot_sequence(input int avail_hold);
        int ack_cycles;
        ack_cycles = 0;
        icap_avail = (avail_hold == 0);
        boot_req = 1'b1;
        for (int d = 0; d < avail_hold; d++) begin
            next_cycle();
            check_value(32'(icap_csib), 32'd1, "csib while icap_avail is low");
        end
        icap_avail = 1'b1;
        while (icap_csib) begin
            check_value(icap_data, swap_bits_in_bytes(IPROG_WORDS[0]), "idle data word");
            check_value(32'(boot_ack), 32'd0, "boot_ack before burst");
            next_cycle();
        end
        for (int k = 0; k < 6; k++) begin
            check_value(32'(icap_csib), 32'd0, $sformatf("csib during word %0d", k));
            check_value(32'(icap_rdwrb), 32'd0, $sformatf("rdwrb during word %0d", k));
            check_value(icap_data, swap_bits_in_bytes(IPROG_WORDS[k]),
                        $sformatf("icap_data word %0d", k));
            check_value(32'(boot_ack), 32'd0, $sformatf("boot_ack during word %0d", k));
            next_cycle();
        end
        check_value(32'(icap_csib), 32'd1, "csib after burst");
        check_value(32'(boot_ack), 32'd1, "boot_ack after burst");
        boot_req = 1'b0;
        while (boot_ack) begin
            check_value(32'(icap_csib), 32'd1, "csib while ack is high");
            next_cycle();
            ack_cycles++;
        end
        // request sync delay plus one cycle for the ack register
        check_value(32'(ack_cycles), 32'(SYNC_DEPTH + 1), "boot_ack fall latency");
    endtask

    task automatic lock_drop(input int hold);
        pll_locked = 1'b0;
        for (int h = 0; h < hold; h++) begin
            next_cycle();
            check_value(32'(core_reset), 32'd1, "core_reset while unlocked");
        end
        pll_locked = 1'b1;
        expect_core_release();
    endtask

    initial begin
        reset = 1'b1;
        pll_locked = 1'b1;
        boot_req = 1'b0;
        icap_avail = 1'b1;
        qspi_core = '0;
        qspi_dq_pin_in = '0;
        lfsr_state = 16'd19854;

        repeat (16) begin
            next_cycle();
        end
        check_value(32'(icap_csib), 32'd1, "csib in reset");
        check_value(32'(icap_rdwrb), 32'd0, "rdwrb in reset");
        check_value(32'(boot_ack), 32'd0, "boot_ack in reset");
        check_value(32'(qspi_pins.cs), 32'd1, "flash cs in reset");
        check_value(32'(qspi_pins.sck), 32'd0, "flash sck in reset");
        check_value(32'(qspi_pins.dq_oe), 32'd0, "flash dq_oe in reset");
        check_value(32'(core_reset), 32'd1, "core_reset in reset");
        reset = 1'b0;
        expect_core_release();

        for (int t = 0; t < TABLE_LEN; t++) begin
            case (TEST_TABLE[t].op)
                OP_FLASH_OUT: flash_out_burst(int'(TEST_TABLE[t].count));
                OP_FLASH_IN:  flash_in_burst(int'(TEST_TABLE[t].count));
                OP_BOOT:      boot_sequence(0);
                OP_BOOT_WAIT: boot_sequence(int'(TEST_TABLE[t].count));
                OP_LOCK_DROP: lock_drop(int'(TEST_TABLE[t].count));
                default:      check_value(32'd0, 32'd1, "unknown table entry");
            endcase
        end

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/board_ctrl_pkg.sv
src/reset_sync.sv
src/signal_sync.sv
src/iprog_sequencer.sv
src/qspi_pin_stage.sv
src/board_ctrl_top.sv
test/tb_board_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the board control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_board_ctrl -o tb_board_ctrl
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/tb_board_ctrl > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF -- '>>> FAIL' "$LOG"; then
    echo "run_sim: testbench reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $run_status"
    exit 1
fi

echo "run_sim: simulation finished cleanly"
exit 0
